/* compile.f */
+incdir+hdl
hdl/ring_bus_pkg.sv
hdl/ring_node.sv
hdl/ring_ctrl.sv
hdl/ring_bus_top.sv
verification/ring_bus_asserts.sv
verification/ring_bus_tb.sv

/* Bender.yml */
package:
  name: ring_bus

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ring_bus_pkg.sv
      - hdl/ring_node.sv
      - hdl/ring_ctrl.sv
      - hdl/ring_bus_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/ring_bus_asserts.sv
      - verification/ring_bus_tb.sv

/* verification/ring_bus_tb.sv */
`timescale 1ns/1ps

`include "ring_bus_consts.svh"

module ring_bus_tb;
	import ring_bus_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int TOTAL_WORDS = 13;
	localparam int TOTAL_MSGS = 9;
	// address, end of message, acknowledge and reset counted as 16 extra bits
	localparam int TOTAL_BITS = TOTAL_WORDS * `DATA_WIDTH + TOTAL_MSGS * (`ADDR_WIDTH + 16);
	localparam int WATCHDOG_NS = TOTAL_BITS * 4 * CLK_PERIOD * 4;

	logic CLK = 1'b0;
	logic RESET;
	bus_addr_t tx_addr [`NUM_NODES];
	bus_data_t tx_data [`NUM_NODES];
	logic [`NUM_NODES-1:0] tx_pend;
	logic [`NUM_NODES-1:0] tx_req;
	logic [`NUM_NODES-1:0] prio;
	logic [`NUM_NODES-1:0] tx_ack;
	bus_addr_t rx_addr [`NUM_NODES];
	bus_data_t rx_data [`NUM_NODES];
	logic [`NUM_NODES-1:0] rx_req;
	logic [`NUM_NODES-1:0] rx_ack = '0;
	logic [`NUM_NODES-1:0] rx_pend;
	logic [`NUM_NODES-1:0] tx_fail;
	logic [`NUM_NODES-1:0] tx_succ;
	logic [`NUM_NODES-1:0] tx_resp_ack;

	logic [`NUM_NODES-1:0] stall = '0;
	logic [31:0] lfsr = 32'd74542;
	bus_data_t msg_words [`NUM_NODES][4];
	// node, pend, address, data
	logic [42:0] rx_log[$];

	// ports in declaration order
	ring_bus_top DUT (
		CLK, RESET, tx_addr, tx_data, tx_pend, tx_req, prio, tx_ack,
		rx_addr, rx_data, rx_req, rx_ack, rx_pend, tx_fail, tx_succ, tx_resp_ack
	);

	bind ring_bus_top ring_bus_asserts u_asserts (
		.CLK(CLK), .RESET(RESET), .tx_req(tx_req), .tx_ack(tx_ack),
		.rx_req(rx_req), .rx_ack(rx_ack), .tx_succ(tx_succ), .tx_fail(tx_fail)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// receivers take every word unless stalled
	always @(negedge CLK)
	begin
		for (int i = 0; i < `NUM_NODES; i++)
		begin
			if (rx_ack[i] && !rx_req[i])
				rx_ack[i] = 1'b0;
			else if (rx_req[i] && !rx_ack[i] && !stall[i])
			begin
				rx_log.push_back({2'(i), rx_pend[i], rx_addr[i], rx_data[i]});
				rx_ack[i] = 1'b1;
			end
		end
	end

	// protocol checker failures end the run too
	always @(negedge CLK)
	begin
		assert (DUT.u_asserts.fail_count == 0)
		else
			stop_on_failure("a protocol assertion in the bound checker failed");
	end

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else
			stop_on_failure($sformatf("** Error at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic random_word(output bus_data_t w);
		w = '0;
		for (int b = 0; b < `DATA_WIDTH; b++)
		begin
			lfsr = lfsr_next(lfsr);
			w = {w[`DATA_WIDTH-2:0], lfsr[0]};
		end
	endtask

	task automatic check_reset_outputs;
		check_value("tx_ack", 0, tx_ack);
		check_value("tx_succ", 0, tx_succ);
		check_value("tx_fail", 0, tx_fail);
		check_value("rx_req", 0, rx_req);
		check_value("rx_pend", 0, rx_pend);
	endtask

	task automatic send_message(input int src, input bus_addr_t dst, input int nwords,
		input logic expect_ok);
		@(negedge CLK);
		tx_addr[src] = dst;
		for (int k = 0; k < nwords; k++)
		begin
			tx_data[src] = msg_words[src][k];
			tx_pend[src] = (k < nwords - 1);
			tx_req[src] = 1'b1;
			do @(negedge CLK); while (!tx_ack[src]);
			tx_req[src] = 1'b0;
			do @(negedge CLK); while (tx_ack[src]);
		end
		while (!(tx_succ[src] || tx_fail[src]))
			@(negedge CLK);
		check_value($sformatf("tx_succ[%0d]", src), expect_ok, tx_succ[src]);
		check_value($sformatf("tx_fail[%0d]", src), !expect_ok, tx_fail[src]);
		tx_resp_ack[src] = 1'b1;
		do @(negedge CLK); while (tx_succ[src] || tx_fail[src]);
		tx_resp_ack[src] = 1'b0;
	endtask

	task automatic expect_rx(input int node, input bus_addr_t addr, input bus_data_t data,
		input logic pend);
		logic [42:0] entry;
		if (rx_log.size() == 0)
			stop_on_failure($sformatf("node %0d never delivered a word for address %h",
				node, addr));
		else
		begin
			entry = rx_log.pop_front();
			check_value("receiving node", node, entry[42:41]);
			check_value($sformatf("rx_addr[%0d]", node), addr, entry[39:32]);
			check_value($sformatf("rx_data[%0d]", node), data, entry[31:0]);
			check_value($sformatf("rx_pend[%0d]", node), pend, entry[40]);
		end
	endtask

	task automatic test_single_word;
		random_word(msg_words[0][0]);
		send_message(0, 8'h20, 1, 1'b1);
		expect_rx(1, 8'h20, msg_words[0][0], 1'b0);
		check_value("extra received words", 0, rx_log.size());
	endtask

	task automatic test_streaming;
		for (int k = 0; k < 4; k++)
			random_word(msg_words[2][k]);
		send_message(2, 8'h10, 4, 1'b1);
		for (int k = 0; k < 4; k++)
			expect_rx(0, 8'h10, msg_words[2][k], k < 3);
		check_value("extra received words", 0, rx_log.size());
	endtask

	task automatic test_no_match;
		random_word(msg_words[1][0]);
		send_message(1, 8'h55, 1, 1'b0);
		check_value("received words", 0, rx_log.size());
	endtask

	task automatic test_arbitration(input logic prio_node1);
		int first;
		random_word(msg_words[0][0]);
		random_word(msg_words[1][0]);
		@(negedge CLK);
		prio[1] = prio_node1;
		fork
			send_message(0, 8'h30, 1, 1'b1);
			send_message(1, 8'h30, 1, 1'b1);
		join
		// node 0 sits nearest the controller and wins without priority
		first = prio_node1 ? 1 : 0;
		expect_rx(2, 8'h30, msg_words[first][0], 1'b0);
		expect_rx(2, 8'h30, msg_words[1 - first][0], 1'b0);
		check_value("extra received words", 0, rx_log.size());
		prio[1] = 1'b0;
	endtask

	task automatic test_back_pressure;
		random_word(msg_words[0][0]);
		random_word(msg_words[0][1]);
		stall[1] = 1'b1;
		send_message(0, 8'h20, 2, 1'b0);
		stall[1] = 1'b0;
		do @(negedge CLK); while (rx_req[1]);
		expect_rx(1, 8'h20, msg_words[0][0], 1'b1);
		check_value("extra received words", 0, rx_log.size());
		// ring must be usable again after the reset sequence
		random_word(msg_words[0][0]);
		send_message(0, 8'h20, 1, 1'b1);
		expect_rx(1, 8'h20, msg_words[0][0], 1'b0);
		check_value("extra received words", 0, rx_log.size());
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		stop_on_failure("watchdog expired before the tests finished");
	end

	initial
	begin
		for (int i = 0; i < `NUM_NODES; i++)
		begin
			tx_addr[i] = '0;
			tx_data[i] = '0;
		end
		tx_pend = '0;
		tx_req = '0;
		prio = '0;
		tx_resp_ack = '0;
		RESET = 1'b0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b1;
		check_reset_outputs();
		test_single_word();
		test_streaming();
		test_no_match();
		test_arbitration(1'b0);
		test_arbitration(1'b1);
		test_back_pressure();
		$display("Test OK");
		$finish;
	end

endmodule

/* verification/ring_bus_asserts.sv */
`timescale 1ns/1ps

`include "ring_bus_consts.svh"

module ring_bus_asserts (
	input logic CLK,
	input logic RESET,
	input logic [`NUM_NODES-1:0] tx_req,
	input logic [`NUM_NODES-1:0] tx_ack,
	input logic [`NUM_NODES-1:0] rx_req,
	input logic [`NUM_NODES-1:0] rx_ack,
	input logic [`NUM_NODES-1:0] tx_succ,
	input logic [`NUM_NODES-1:0] tx_fail
);

	int fail_count = 0;

	// one result per message
	a_result_unique: assert property (@(posedge CLK) disable iff (!RESET)
		(tx_succ & tx_fail) == '0)
	else
	begin
		fail_count++;
		$error("tx_succ and tx_fail high together: %b %b", tx_succ, tx_fail);
	end

	for (genvar i = 0; i < `NUM_NODES; i++)
	begin : g_node
		a_rx_req_hold: assert property (@(posedge CLK) disable iff (!RESET)
			rx_req[i] && !rx_ack[i] |=> rx_req[i])
		else
		begin
			fail_count++;
			$error("rx_req[%0d] dropped before rx_ack", i);
		end

		// four-phase release of the transmit strobe
		a_tx_ack_release: assert property (@(posedge CLK) disable iff (!RESET)
			$fell(tx_req[i]) |=> !tx_ack[i])
		else
		begin
			fail_count++;
			$error("tx_ack[%0d] still high after tx_req fell", i);
		end
	end

endmodule

/* hdl/ring_bus_top.sv */
`timescale 1ns/1ps

`include "ring_bus_consts.svh"

module ring_bus_top (
	input logic CLK,
	input logic RESET,
	input ring_bus_pkg::bus_addr_t tx_addr [`NUM_NODES],
	input ring_bus_pkg::bus_data_t tx_data [`NUM_NODES],
	input logic [`NUM_NODES-1:0] tx_pend,
	input logic [`NUM_NODES-1:0] tx_req,
	input logic [`NUM_NODES-1:0] prio,
	output logic [`NUM_NODES-1:0] tx_ack,
	output ring_bus_pkg::bus_addr_t rx_addr [`NUM_NODES],
	output ring_bus_pkg::bus_data_t rx_data [`NUM_NODES],
	output logic [`NUM_NODES-1:0] rx_req,
	input logic [`NUM_NODES-1:0] rx_ack,
	output logic [`NUM_NODES-1:0] rx_pend,
	output logic [`NUM_NODES-1:0] tx_fail,
	output logic [`NUM_NODES-1:0] tx_succ,
	input logic [`NUM_NODES-1:0] tx_resp_ack
);
	// ring[0] leaves the controller, ring[NUM_NODES] returns to it
	logic [`NUM_NODES:0] ring;

	ring_ctrl u_ctrl (
		.CLK(CLK),
		.RESET(RESET),
		.line_in(ring[`NUM_NODES]),
		.line_out(ring[0])
	);

	for (genvar i = 0; i < `NUM_NODES; i++)
	begin : g_node
		ring_node #(
			.ADDRESS(ring_bus_pkg::bus_addr_t'(8'h10 * (i + 1))),
			.ADDRESS_MASK(8'hff)
		) u_node (
			.CLK(CLK), .RESET(RESET), .DIN(ring[i]), .DOUT(ring[i+1]),
			.TX_ADDR(tx_addr[i]), .TX_DATA(tx_data[i]), .TX_PEND(tx_pend[i]),
			.TX_REQ(tx_req[i]), .PRIORITY(prio[i]), .TX_ACK(tx_ack[i]),
			.RX_ADDR(rx_addr[i]), .RX_DATA(rx_data[i]), .RX_REQ(rx_req[i]),
			.RX_ACK(rx_ack[i]), .RX_PEND(rx_pend[i]), .TX_FAIL(tx_fail[i]),
			.TX_SUCC(tx_succ[i]), .TX_RESP_ACK(tx_resp_ack[i])
		);
	end

endmodule

/* hdl/ring_ctrl.sv */
`timescale 1ns/1ps

`include "ring_bus_consts.svh"

module ring_ctrl (
	input logic CLK,
	input logic RESET,
	input logic line_in,
	output logic line_out
);
	import ring_bus_pkg::*;

	localparam logic [2:0] RST = `RST_SEQ;

	bus_phase_e phase;
	logic [2:0] hist;
	logic d1_q;
	logic ack_wait;
	logic inject;
	logic [1:0] inj_cnt;

	// hist sees what node 0 sees, so the phase stays in step with the ring
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= ph_idle;
			hist <= '0;
			d1_q <= 1'b0;
			ack_wait <= 1'b0;
			inject <= 1'b0;
			inj_cnt <= '0;
		end
		else
		begin
			if ((phase == ph_drive1) || (phase == ph_drive2) ||
				(phase == ph_phase_align) || (phase == ph_bus_reset))
				hist <= {hist[1:0], line_out};
			case (phase)
				ph_idle:
				begin
					// line came back high, nobody asked for the bus
					if (line_in)
					begin
						inject <= 1'b1;
						inj_cnt <= '0;
					end
					phase <= ph_arbi_resolved;
				end
				ph_arbi_resolved:
					phase <= ph_prio_drive;
				ph_prio_drive:
					phase <= ph_prio_latch;
				ph_prio_latch:
					phase <= ph_drive1;
				ph_drive1:
				begin
					d1_q <= line_in;
					if (inject)
						inj_cnt <= inj_cnt + 1'b1;
					phase <= ph_latch1;
				end
				ph_drive2:
				begin
					if (inject)
						inj_cnt <= inj_cnt + 1'b1;
					else if (ack_wait)
					begin
						// acknowledge pair passed, reset follows
						ack_wait <= 1'b0;
						inject <= 1'b1;
						inj_cnt <= '0;
					end
					else if (line_in != d1_q)
						ack_wait <= 1'b1;
					phase <= ph_latch2;
				end
				ph_latch1:
					phase <= (hist == RST) ? ph_phase_align : ph_drive2;
				ph_latch2:
					phase <= (hist == RST) ? ph_phase_align : ph_drive1;
				ph_phase_align:
				begin
					inject <= 1'b0;
					phase <= ph_bus_reset;
				end
				ph_bus_reset:
					if (hist == 3'b111)
						phase <= ph_idle;
				default:
					phase <= ph_idle;
			endcase
		end
	end

	always_comb
	begin
		case (phase)
			ph_prio_drive:
				line_out = inject ? 1'b1 : line_in;
			ph_drive1, ph_drive2:
				line_out = inject ? RST[2'd2 - inj_cnt] : line_in;
			default:
				line_out = 1'b1;
		endcase
	end

endmodule

/* hdl/ring_node.sv */
`timescale 1ns/1ps

`include "ring_bus_consts.svh"

module ring_node #(
	parameter ring_bus_pkg::bus_addr_t ADDRESS = 8'hef,
	parameter ring_bus_pkg::bus_addr_t ADDRESS_MASK = 8'hff
) (
	input logic CLK,
	input logic RESET,
	input logic DIN,
	output logic DOUT,
	input ring_bus_pkg::bus_addr_t TX_ADDR,
	input ring_bus_pkg::bus_data_t TX_DATA,
	input logic TX_PEND,
	input logic TX_REQ,
	input logic PRIORITY,
	output logic TX_ACK,
	output ring_bus_pkg::bus_addr_t RX_ADDR,
	output ring_bus_pkg::bus_data_t RX_DATA,
	output logic RX_REQ,
	input logic RX_ACK,
	output logic RX_PEND,
	output logic TX_FAIL,
	output logic TX_SUCC,
	input logic TX_RESP_ACK
);
	import ring_bus_pkg::*;

	localparam logic [1:0] MES = `MES_SEQ;
	localparam logic [1:0] ACK = `ACK_SEQ;
	localparam logic [2:0] RST = `RST_SEQ;

	bus_phase_e phase, phase_n;
	node_mode_e mode, mode_n;
	tx_state_e tx_state, tx_state_n;
	rx_state_e rx_state, rx_state_n;
	bit_pos_t bit_pos, bit_pos_n;
	logic [4:0] in_buf;
	logic out_reg, out_reg_n;
	logic tx_ack_n, tx_fail_n, tx_succ_n, rx_req_n, rx_pend_n;
	logic pend_q, pend_n;
	bus_addr_t addr_q, addr_n, rx_addr_n;
	bus_data_t data_q, data_n, rx_data_n, rx_buf, rx_buf_n;

	logic addr_bit, data_bit, pair_xor, addr_match, rst_seen, tx_drives;

	assign addr_bit = addr_q[bit_pos[2:0]];
	assign data_bit = data_q[bit_pos];
	assign pair_xor = in_buf[0] ^ in_buf[1];
	assign addr_match = ((RX_ADDR ^ ADDRESS) & ADDRESS_MASK) == '0;
	assign rst_seen = in_buf[2:0] == RST;
	assign tx_drives = (tx_state == tx_st_addr) || (tx_state == tx_st_data);

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			phase <= ph_idle;
			mode <= mode_fwd;
			tx_state <= tx_st_fwd;
			rx_state <= rx_st_addr;
			bit_pos <= bit_pos_t'(`ADDR_WIDTH - 1);
			out_reg <= 1'b1;
			pend_q <= 1'b0;
			TX_ACK <= 1'b0;
			TX_FAIL <= 1'b0;
			TX_SUCC <= 1'b0;
			RX_REQ <= 1'b0;
			RX_PEND <= 1'b0;
			in_buf <= '0;
		end
		else
		begin
			phase <= phase_n;
			mode <= mode_n;
			tx_state <= tx_state_n;
			rx_state <= rx_state_n;
			bit_pos <= bit_pos_n;
			out_reg <= out_reg_n;
			pend_q <= pend_n;
			TX_ACK <= tx_ack_n;
			TX_FAIL <= tx_fail_n;
			TX_SUCC <= tx_succ_n;
			RX_REQ <= rx_req_n;
			RX_PEND <= rx_pend_n;
			// line is only sampled in drive and reset phases
			if ((phase == ph_drive1) || (phase == ph_drive2) ||
				(phase == ph_phase_align) || (phase == ph_bus_reset))
				in_buf <= {in_buf[3:0], DIN};
		end
	end

	always_ff @(posedge CLK)
	begin
		addr_q <= addr_n;
		data_q <= data_n;
		RX_ADDR <= rx_addr_n;
		RX_DATA <= rx_data_n;
		rx_buf <= rx_buf_n;
	end

	always_comb
	begin
		phase_n = phase;
		mode_n = mode;
		tx_state_n = tx_state;
		rx_state_n = rx_state;
		bit_pos_n = bit_pos;
		out_reg_n = out_reg;
		pend_n = pend_q;
		addr_n = addr_q;
		data_n = data_q;
		rx_addr_n = RX_ADDR;
		rx_data_n = RX_DATA;
		rx_buf_n = rx_buf;
		tx_ack_n = TX_ACK;
		tx_fail_n = TX_FAIL;
		tx_succ_n = TX_SUCC;
		rx_req_n = RX_REQ;
		rx_pend_n = RX_PEND;

		// four-phase strobes
		if (TX_ACK && !TX_REQ)
			tx_ack_n = 1'b0;
		if (RX_REQ && RX_ACK)
		begin
			rx_req_n = 1'b0;
			rx_pend_n = 1'b0;
		end
		if (TX_RESP_ACK)
		begin
			tx_fail_n = 1'b0;
			tx_succ_n = 1'b0;
		end

		case (phase)
			ph_idle:
			begin
				mode_n = (DIN && TX_REQ) ? mode_tx_non_prio : mode_rx;
				bit_pos_n = bit_pos_t'(`ADDR_WIDTH - 1);
				phase_n = ph_arbi_resolved;
			end
			ph_arbi_resolved:
				phase_n = ph_prio_drive;
			ph_prio_drive:
			begin
				// candidate keeps the bus on a quiet line, a priority node on a flip
				if ((mode == mode_tx_non_prio) ^ (DIN ^ DOUT))
				begin
					addr_n = TX_ADDR;
					data_n = TX_DATA;
					pend_n = TX_PEND;
					tx_ack_n = 1'b1;
					mode_n = mode_tx;
					tx_state_n = tx_st_addr;
				end
				else
				begin
					mode_n = mode_rx;
					rx_state_n = rx_st_addr;
				end
				phase_n = ph_prio_latch;
			end
			ph_prio_latch:
			begin
				if (mode == mode_tx)
					out_reg_n = addr_bit;
				phase_n = ph_drive1;
			end
			ph_drive1:
			begin
				if ((mode == mode_rx) && (rx_state == rx_st_data) && !addr_match)
					mode_n = mode_fwd;
				phase_n = ph_latch1;
			end
			ph_latch1:
			begin
				if (rst_seen)
				begin
					phase_n = ph_phase_align;
					if ((mode == mode_tx) && tx_drives)
						tx_fail_n = 1'b1;
					if ((mode == mode_tx) && (tx_state == tx_st_wait_ack2))
						tx_succ_n = 1'b1;
				end
				else
				begin
					phase_n = ph_drive2;
					if (mode == mode_tx)
					begin
						case (tx_state)
							tx_st_error:
								out_reg_n = ~out_reg;
							tx_st_eot0:
							begin
								tx_state_n = tx_st_eot1;
								out_reg_n = MES[0];
							end
							tx_st_wait_ack2:
							begin
								tx_state_n = tx_st_fwd;
								tx_fail_n = 1'b1;
							end
							default:
								out_reg_n = out_reg;
						endcase
					end
					else if (mode == mode_rx)
					begin
						if (rx_state == rx_st_drive_ack0)
						begin
							rx_state_n = rx_st_drive_ack1;
							out_reg_n = ACK[0];
						end
						else if (rx_state == rx_st_error)
							out_reg_n = ~out_reg;
					end
				end
			end
			ph_drive2:
			begin
				phase_n = ph_latch2;
				if ((mode == mode_tx) && tx_drives)
				begin
					if (bit_pos != '0)
						bit_pos_n = bit_pos - 1'b1;
					else
					begin
						bit_pos_n = bit_pos_t'(`DATA_WIDTH - 1);
						if (tx_state == tx_st_addr)
							tx_state_n = tx_st_data;
						else if (pend_q && TX_REQ)
						begin
							pend_n = TX_PEND;
							data_n = TX_DATA;
							tx_ack_n = 1'b1;
						end
						else if (pend_q)
							tx_state_n = tx_st_underflow;
						else
							tx_state_n = tx_st_eot0;
					end
				end
			end
			ph_latch2:
			begin
				if (rst_seen)
				begin
					phase_n = ph_phase_align;
					if ((mode == mode_tx) && tx_drives)
						tx_fail_n = 1'b1;
				end
				else
				begin
					phase_n = ph_drive1;
					if (mode == mode_tx)
					begin
						case (tx_state)
							tx_st_addr, tx_st_data, tx_st_underflow:
							begin
								if ((tx_state != tx_st_underflow) &&
									(in_buf[1:0] == {2{out_reg}}))
									out_reg_n = (tx_state == tx_st_addr) ? addr_bit : data_bit;
								else
								begin
									// line disagrees or no word, start burst
									tx_state_n = tx_st_error;
									tx_fail_n = 1'b1;
									out_reg_n = ~MES[1];
									bit_pos_n = bit_pos_t'(`ERROR_RST_CNT - 1);
								end
							end
							tx_st_eot0:
								out_reg_n = MES[1];
							tx_st_eot1:
								tx_state_n = tx_st_wait_ack0;
							tx_st_wait_ack0, tx_st_wait_ack1:
							begin
								if ((tx_state == tx_st_wait_ack0) && (in_buf[1:0] == ACK))
									tx_state_n = tx_st_wait_ack1;
								else if ((tx_state == tx_st_wait_ack1) &&
									(in_buf[1:0] == RST[2:1]))
									tx_state_n = tx_st_wait_ack2;
								else
								begin
									tx_fail_n = 1'b1;
									tx_state_n = tx_st_fwd;
								end
							end
							tx_st_error:
							begin
								if (bit_pos != '0)
								begin
									bit_pos_n = bit_pos - 1'b1;
									out_reg_n = ~out_reg;
								end
								else
									tx_state_n = tx_st_fwd;
							end
							default:
								tx_state_n = tx_state;
						endcase
					end
					else if (mode == mode_rx)
					begin
						case (rx_state)
							rx_st_addr:
							begin
								if (pair_xor)
									rx_state_n = rx_st_fwd;
								else
								begin
									rx_addr_n = {RX_ADDR[`ADDR_WIDTH-2:0], in_buf[0]};
									if (bit_pos != '0)
										bit_pos_n = bit_pos - 1'b1;
									else
									begin
										bit_pos_n = bit_pos_t'(`DATA_WIDTH - 1);
										rx_state_n = rx_st_data;
									end
								end
							end
							rx_st_data:
							begin
								if (pair_xor)
									rx_state_n = rx_st_fwd;
								else
								begin
									rx_buf_n = {rx_buf[`DATA_WIDTH-2:0], in_buf[0]};
									if (bit_pos != '0)
										bit_pos_n = bit_pos - 1'b1;
									else
									begin
										bit_pos_n = bit_pos_t'(`DATA_WIDTH - 1);
										rx_state_n = rx_st_cont;
									end
								end
							end
							rx_st_cont:
							begin
								if (RX_REQ || RX_ACK)
								begin
									// previous word not taken yet
									bit_pos_n = bit_pos_t'(`ERROR_RST_CNT - 1);
									if (pair_xor)
										rx_state_n = rx_st_fwd;
									else
									begin
										out_reg_n = ~MES[1];
										rx_state_n = rx_st_error;
									end
								end
								else
								begin
									rx_req_n = 1'b1;
									rx_data_n = rx_buf;
									if (pair_xor)
									begin
										rx_pend_n = 1'b0;
										if (in_buf[1:0] == MES)
										begin
											rx_state_n = rx_st_drive_ack0;
											out_reg_n = ACK[1];
										end
										else
											rx_state_n = rx_st_fwd;
									end
									else
									begin
										// first bit of the next word is already here
										rx_pend_n = 1'b1;
										bit_pos_n = bit_pos - 1'b1;
										rx_buf_n = {rx_buf[`DATA_WIDTH-2:0], in_buf[0]};
										rx_state_n = rx_st_data;
									end
								end
							end
							rx_st_error:
							begin
								if (bit_pos != '0)
								begin
									bit_pos_n = bit_pos - 1'b1;
									out_reg_n = ~out_reg;
								end
								else
									rx_state_n = rx_st_fwd;
							end
							rx_st_drive_ack1:
								rx_state_n = rx_st_fwd;
							default:
								rx_state_n = rx_state;
						endcase
					end
				end
			end
			ph_phase_align:
				phase_n = ph_bus_reset;
			ph_bus_reset:
			begin
				if (in_buf[2:0] == 3'b111)
				begin
					phase_n = ph_idle;
					mode_n = mode_fwd;
				end
			end
			default:
				phase_n = ph_idle;
		endcase
	end

	// line mux
	always_comb
	begin
		DOUT = DIN;
		case (phase)
			ph_idle:
				DOUT = DIN & ~TX_REQ;
			ph_arbi_resolved:
				if (mode == mode_tx_non_prio)
					DOUT = 1'b0;
			ph_prio_drive:
			begin
				if ((mode == mode_tx_non_prio) && !PRIORITY)
					DOUT = 1'b0;
				else if ((mode == mode_rx) && PRIORITY && TX_REQ)
					DOUT = 1'b1;
			end
			ph_prio_latch:
				DOUT = 1'b0;
			ph_drive1:
			begin
				if ((mode == mode_tx) && (tx_drives || (tx_state == tx_st_eot0) ||
					(tx_state == tx_st_error)))
					DOUT = out_reg;
				else if ((mode == mode_rx) && ((rx_state == rx_st_drive_ack0) ||
					(rx_state == rx_st_error)))
					DOUT = out_reg;
			end
			ph_drive2:
			begin
				if ((mode == mode_tx) && (tx_drives || (tx_state == tx_st_eot1) ||
					(tx_state == tx_st_error)))
					DOUT = out_reg;
				else if ((mode == mode_rx) && ((rx_state == rx_st_drive_ack1) ||
					(rx_state == rx_st_error)))
					DOUT = out_reg;
			end
			ph_latch1, ph_latch2:
			begin
				if (((mode == mode_tx) && (tx_state == tx_st_error)) ||
					((mode == mode_rx) && (rx_state == rx_st_error)))
					DOUT = out_reg;
			end
			default:
				DOUT = DIN;
		endcase
	end

endmodule

/* hdl/ring_bus_pkg.sv */
package ring_bus_pkg;

`include "ring_bus_consts.svh"

	typedef logic [`ADDR_WIDTH-1:0] bus_addr_t;
	typedef logic [`DATA_WIDTH-1:0] bus_data_t;
	typedef logic [4:0] bit_pos_t;

	typedef enum logic [3:0] {
		ph_idle, ph_arbi_resolved, ph_prio_drive, ph_prio_latch, ph_drive1,
		ph_latch1, ph_drive2, ph_latch2, ph_phase_align, ph_bus_reset
	} bus_phase_e;

	typedef enum logic [1:0] {mode_tx_non_prio, mode_tx, mode_rx, mode_fwd} node_mode_e;

	typedef enum logic [3:0] {
		tx_st_addr, tx_st_data, tx_st_eot0, tx_st_eot1, tx_st_wait_ack0,
		tx_st_wait_ack1, tx_st_wait_ack2, tx_st_underflow, tx_st_error, tx_st_fwd
	} tx_state_e;

	typedef enum logic [2:0] {
		rx_st_addr, rx_st_data, rx_st_cont, rx_st_drive_ack0, rx_st_drive_ack1,
		rx_st_error, rx_st_fwd
	} rx_state_e;

endpackage

/* hdl/ring_bus_consts.svh */
`ifndef RING_BUS_CONSTS_SVH
`define RING_BUS_CONSTS_SVH

// field widths
`define ADDR_WIDTH 8
`define DATA_WIDTH 32

// ring positions, controller excluded
`define NUM_NODES 3

// line pairs, upper bit goes out in drive1
`define MES_SEQ 2'b01
`define ACK_SEQ 2'b10

// low-high-low over three drive slots
`define RST_SEQ 3'b010

// toggling pairs per error burst
`define ERROR_RST_CNT 1

`endif
